// File: rtl/dcache_pkg.sv
// shared widths and types for a two-way cache of four-word lines addressed by 30-bit word address

package dcache_pkg;

    //////////////////////
    // address and data widths
    //////////////////////

    localparam int tag_w          = 20;
    localparam int index_w        = 8;
    localparam int offset_w       = 2;
    localparam int word_w         = 32;
    localparam int words_per_line = 4;

    localparam int line_w = word_w * words_per_line;   // 128 bits
    localparam int addr_w = tag_w + index_w + offset_w; // word address

    //////////////////////
    // plain vector types
    //////////////////////

    typedef logic [tag_w-1:0]    tag_t;
    typedef logic [index_w-1:0]  index_t;
    typedef logic [offset_w-1:0] offset_t;
    typedef logic [word_w-1:0]   word_t;
    typedef logic [line_w-1:0]   line_t;
    typedef logic [addr_w-1:0]   word_addr_t;          // tag, then index, then offset

    //////////////////////
    // grouped signals
    //////////////////////

    // one way's read port as seen after the array lookup
    typedef struct packed {
        logic  valid;
        logic  dirty;
        tag_t  tag;
        line_t line;
    } way_rd_t;

    typedef struct packed {
        logic       write;                             // 1 = store
        word_addr_t addr;
        word_t      wr_data;
    } cpu_req_t;

    // controls toward the tag and data arrays of both ways
    typedef struct packed {
        logic [1:0]   re;                              // per way
        logic [1:0]   we;                              // per way
        index_t       index;
        offset_t      offset;
        logic [tag_w:0] tag_wd;                        // valid bit over tag
        word_t        word_wd;
        line_t        line_wd;
        logic         line_we;                         // 0 = word at offset only
    } array_ctl_t;

    //////////////////////
    // access FSM
    //////////////////////

    typedef enum logic [2:0] {
        dc_idle,
        dc_access,
        dc_wait_clean,
        dc_wait_dirty,
        dc_merge_write
    } dc_state_t;

endpackage

// File: rtl/dcache_way_select.sv
// purely combinational tag compare and victim choice for two ways with lru high meaning way 1

`timescale 1ns/100ps

module dcache_way_select (
    input  dcache_pkg::tag_t    tag,
    input  dcache_pkg::way_rd_t way0,
    input  dcache_pkg::way_rd_t way1,
    input  logic                lru,
    output logic                hit,
    output logic                hit_way,
    output logic                victim_way,
    output logic                victim_dirty
);

    logic hit0;
    logic hit1;
    logic dirty0;
    logic dirty1;

    //////////////////////
    // tag compare
    //////////////////////

    assign hit0 = way0.valid && (way0.tag == tag);
    assign hit1 = way1.valid && (way1.tag == tag);

    assign hit     = hit0 || hit1;
    assign hit_way = !hit0 && hit1;                   // way 0 wins on a double hit

    //////////////////////
    // victim choice
    //////////////////////

    assign dirty0 = way0.valid && way0.dirty;
    assign dirty1 = way1.valid && way1.dirty;

    always_comb begin
        if (!way0.valid) begin
            victim_way = 1'b0;                         // fill empty way 0 first
        end else if (!way1.valid) begin
            victim_way = 1'b1;
        end else begin
            victim_way = lru;                          // both full
        end
    end

    // a miss needs a writeback only if the victim holds modified data
    assign victim_dirty = victim_way ? dirty1 : dirty0;

endmodule

// File: rtl/dcache_read_path.sv
// combinational CPU read mux with no register stage so read_data follows its inputs in the same cycle

`timescale 1ns/100ps

module dcache_read_path (
    input  dcache_pkg::line_t   way0_line,
    input  dcache_pkg::line_t   way1_line,
    input  logic                hit_way,
    input  dcache_pkg::line_t   refill_line,
    input  logic                from_refill,
    input  dcache_pkg::offset_t offset,
    output dcache_pkg::word_t   read_data
);

    dcache_pkg::line_t                                 src_line;
    dcache_pkg::word_t [dcache_pkg::words_per_line-1:0] src_words;

    //////////////////////
    // line source
    //////////////////////

    always_comb begin
        if (from_refill) begin
            src_line = refill_line;                    // missed word forwarded from L2
        end else if (hit_way) begin
            src_line = way1_line;
        end else begin
            src_line = way0_line;
        end
    end

    //////////////////////
    // word within line
    //////////////////////

    // word n sits at bits 32n+31 down to 32n
    assign src_words = src_line;

    assign read_data = src_words[offset];

endmodule

// File: rtl/dcache_ctrl_fsm.sv
// one access in flight at a time and a single pending miss that waits for one L2 refill strobe

`timescale 1ns/100ps

module dcache_ctrl_fsm (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   access,
    input  dcache_pkg::cpu_req_t   req,
    input  logic                   hit,
    input  logic                   hit_way,
    input  logic                   victim_way,
    input  logic                   victim_dirty,
    input  logic                   l2_busy,
    input  logic                   l2_grant,
    input  logic                   refill_valid,
    input  dcache_pkg::line_t      refill_line,
    output dcache_pkg::tag_t       lookup_tag,
    output logic                   from_refill,
    output dcache_pkg::offset_t    offset,
    output logic                   miss_stall,
    output logic                   drq,
    output logic                   access_l2_clean,
    output logic                   access_l2_dirty,
    output dcache_pkg::array_ctl_t arr
);

    dcache_pkg::dc_state_t  state;
    dcache_pkg::dc_state_t  state_nxt;
    dcache_pkg::cpu_req_t   req_q;
    dcache_pkg::word_addr_t cur_addr;
    dcache_pkg::index_t     cur_index;
    logic                   victim_q;
    logic                   pending_q;
    logic                   pending_set;
    logic                   pending_clr;
    logic                   latch_req;
    logic                   latch_victim;

    //////////////////////
    // address fields
    //////////////////////

    // incoming request only while idle with no miss outstanding
    assign cur_addr = (state == dcache_pkg::dc_idle && !pending_q) ? req.addr : req_q.addr;

    assign lookup_tag = cur_addr[dcache_pkg::addr_w-1 -: dcache_pkg::tag_w];
    assign cur_index  = cur_addr[dcache_pkg::offset_w +: dcache_pkg::index_w];
    assign offset     = cur_addr[dcache_pkg::offset_w-1:0];

    //////////////////////
    // next state and outputs
    //////////////////////

    always_comb begin
        state_nxt       = state;
        miss_stall      = 1'b0;
        drq             = 1'b0;
        access_l2_clean = 1'b0;
        access_l2_dirty = 1'b0;
        from_refill     = 1'b0;
        latch_req       = 1'b0;
        latch_victim    = 1'b0;
        pending_set     = 1'b0;
        pending_clr     = 1'b0;
        arr.re          = 2'b00;
        arr.we          = 2'b00;
        arr.index       = cur_index;
        arr.offset      = offset;
        arr.tag_wd      = {1'b1, lookup_tag};
        arr.word_wd     = req_q.wr_data;
        arr.line_wd     = refill_line;
        arr.line_we     = 1'b0;
        case (state)
            dcache_pkg::dc_idle: begin
                if (pending_q) begin
                    miss_stall = 1'b1;                 // held until L2 returns the line
                    if (refill_valid) begin
                        arr.we[victim_q] = 1'b1;
                        arr.line_we      = 1'b1;
                        pending_clr      = 1'b1;
                        if (req_q.write) begin
                            state_nxt = dcache_pkg::dc_merge_write;
                        end else begin
                            from_refill = 1'b1;
                            miss_stall  = 1'b0;
                        end
                    end
                end else if (access) begin
                    arr.re    = 2'b11;                 // look up both ways
                    latch_req = 1'b1;
                    state_nxt = dcache_pkg::dc_access;
                end
            end
            dcache_pkg::dc_access: begin
                if (hit) begin
                    state_nxt = dcache_pkg::dc_idle;
                    if (req_q.write) begin
                        arr.we[hit_way] = 1'b1;        // word write into hit way
                    end
                end else begin
                    miss_stall   = 1'b1;
                    drq          = 1'b1;
                    latch_victim = 1'b1;
                    if (!l2_busy) begin
                        if (l2_grant) begin
                            access_l2_dirty = victim_dirty;
                            access_l2_clean = !victim_dirty;
                            pending_set     = 1'b1;
                            state_nxt       = dcache_pkg::dc_idle;
                        end else if (victim_dirty) begin
                            state_nxt = dcache_pkg::dc_wait_dirty;
                        end else begin
                            state_nxt = dcache_pkg::dc_wait_clean;
                        end
                    end
                end
            end
            dcache_pkg::dc_wait_clean,
            dcache_pkg::dc_wait_dirty: begin
                miss_stall = 1'b1;
                drq        = 1'b1;
                if (l2_grant) begin
                    access_l2_clean = (state == dcache_pkg::dc_wait_clean);
                    access_l2_dirty = (state == dcache_pkg::dc_wait_dirty);
                    pending_set     = 1'b1;
                    state_nxt       = dcache_pkg::dc_idle;
                end
            end
            dcache_pkg::dc_merge_write: begin
                arr.we[victim_q] = 1'b1;               // store word over fresh line
                state_nxt        = dcache_pkg::dc_idle;
            end
            default: begin
                state_nxt = dcache_pkg::dc_idle;
            end
        endcase
    end

    //////////////////////
    // registers
    //////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= dcache_pkg::dc_idle;
            pending_q <= 1'b0;
        end else begin
            state <= state_nxt;
            if (pending_set) begin
                pending_q <= 1'b1;
            end else if (pending_clr) begin
                pending_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (latch_req) begin
            req_q <= req;
        end
        if (latch_victim) begin
            victim_q <= victim_way;                    // kept for the refill write
        end
    end

endmodule

// File: rtl/dcache_ctrl.sv
// arrays are read one cycle after re and L2 refill arrives as a single refill_valid strobe

`timescale 1ns/100ps

module dcache_ctrl (
    input  logic                   clk,
    input  logic                   rst,
    input  dcache_pkg::cpu_req_t   req,
    input  logic                   access,
    input  dcache_pkg::way_rd_t    way0,
    input  dcache_pkg::way_rd_t    way1,
    input  logic                   lru,
    input  logic                   l2_busy,
    input  logic                   l2_grant,
    input  logic                   refill_valid,
    input  dcache_pkg::line_t      refill_line,
    output dcache_pkg::word_t      read_data,
    output logic                   miss_stall,
    output logic                   drq,
    output logic                   access_l2_clean,
    output logic                   access_l2_dirty,
    output dcache_pkg::array_ctl_t arr
);

    dcache_pkg::tag_t    lookup_tag;
    dcache_pkg::offset_t offset;
    logic                hit;
    logic                hit_way;
    logic                victim_way;
    logic                victim_dirty;
    logic                from_refill;

    //////////////////////
    // lookup and data
    //////////////////////

    dcache_way_select u_way_select (
        .tag          (lookup_tag),
        .way0         (way0),
        .way1         (way1),
        .lru          (lru),
        .hit          (hit),
        .hit_way      (hit_way),
        .victim_way   (victim_way),
        .victim_dirty (victim_dirty)
    );

    dcache_read_path u_read_path (
        .way0_line   (way0.line),
        .way1_line   (way1.line),
        .hit_way     (hit_way),
        .refill_line (refill_line),
        .from_refill (from_refill),
        .offset      (offset),
        .read_data   (read_data)
    );

    //////////////////////
    // control
    //////////////////////

    dcache_ctrl_fsm u_ctrl_fsm (
        .clk             (clk),
        .rst             (rst),
        .access          (access),
        .req             (req),
        .hit             (hit),
        .hit_way         (hit_way),
        .victim_way      (victim_way),
        .victim_dirty    (victim_dirty),
        .l2_busy         (l2_busy),
        .l2_grant        (l2_grant),
        .refill_valid    (refill_valid),
        .refill_line     (refill_line),
        .lookup_tag      (lookup_tag),
        .from_refill     (from_refill),
        .offset          (offset),
        .miss_stall      (miss_stall),
        .drq             (drq),
        .access_l2_clean (access_l2_clean),
        .access_l2_dirty (access_l2_dirty),
        .arr             (arr)
    );

endmodule

// File: sim/dcache_ctrl_checker.sv
// sampled on clk with reset masking so only protocol rules of the control FSM are covered here

`timescale 1ns/100ps

module dcache_ctrl_checker (
    input logic       clk,
    input logic       rst,
    input logic       access_l2_clean,
    input logic       access_l2_dirty,
    input logic       drq,
    input logic       miss_stall,
    input logic [1:0] we
);

    a_one_l2_access: assert property (@(posedge clk) disable iff (rst)
        !(access_l2_clean && access_l2_dirty))
        else $error("clean and dirty L2 access raised together");

    a_one_way_write: assert property (@(posedge clk) disable iff (rst) we != 2'b11)
        else $error("both ways written in one cycle");

    a_drq_stalls: assert property (@(posedge clk) disable iff (rst) drq |-> miss_stall)
        else $error("drq high without miss_stall");

    a_clean_pulse: assert property (@(posedge clk) disable iff (rst)
        access_l2_clean |=> !access_l2_clean)
        else $error("access_l2_clean longer than one cycle");

    a_dirty_pulse: assert property (@(posedge clk) disable iff (rst)
        access_l2_dirty |=> !access_l2_dirty)
        else $error("access_l2_dirty longer than one cycle");

endmodule

bind dcache_ctrl_fsm dcache_ctrl_checker u_checker (
    .clk             (clk),
    .rst             (rst),
    .access_l2_clean (access_l2_clean),
    .access_l2_dirty (access_l2_dirty),
    .drq             (drq),
    .miss_stall      (miss_stall),
    .we              (arr.we)
);

// File: sim/dcache_ctrl_tb.sv
// one access at a time, every row uses its own set index and all other sets read back as empty

`timescale 1ns/100ps

module dcache_ctrl_tb;

    localparam int num_rows = 12;
    localparam dcache_pkg::tag_t tag_a = 20'h3a5c1;    // tag of every request
    localparam dcache_pkg::tag_t tag_b = 20'h0f00d;
    localparam dcache_pkg::tag_t tag_c = 20'h7b2e4;

    typedef struct {
        string                  name;
        dcache_pkg::word_addr_t addr;
        logic                   write;
        dcache_pkg::word_t      wr_data;
        logic [1:0]             valid;                 // bit n for way n
        logic [1:0]             dirty;
        dcache_pkg::tag_t       tag0;
        dcache_pkg::tag_t       tag1;
        logic                   lru;
        int                     grant_delay;           // cycles of miss before l2_grant
        logic                   busy_first;
        logic                   exp_hit;
        logic                   exp_way;               // hit way, or victim on a miss
        logic                   exp_dirty;
    } test_row_t;

    logic                   clk = 1'b0;
    logic                   rst;
    dcache_pkg::cpu_req_t   req;
    logic                   access;
    dcache_pkg::way_rd_t    way0 = '0;
    dcache_pkg::way_rd_t    way1 = '0;
    logic                   lru;
    logic                   l2_busy;
    logic                   l2_grant;
    logic                   refill_valid;
    dcache_pkg::line_t      refill_line;
    dcache_pkg::word_t      read_data;
    logic                   miss_stall;
    logic                   drq;
    logic                   access_l2_clean;
    logic                   access_l2_dirty;
    dcache_pkg::array_ctl_t arr;

    test_row_t              rows [num_rows];
    dcache_pkg::way_rd_t    cur_way0;
    dcache_pkg::way_rd_t    cur_way1;
    dcache_pkg::index_t     cur_index;
    string                  cur_test;
    logic [31:0]            lfsr_state = 32'h2651;

    always #20 clk = ~clk;

    dcache_ctrl u_dcache_ctrl (
        .clk             (clk),
        .rst             (rst),
        .req             (req),
        .access          (access),
        .way0            (way0),
        .way1            (way1),
        .lru             (lru),
        .l2_busy         (l2_busy),
        .l2_grant        (l2_grant),
        .refill_valid    (refill_valid),
        .refill_line     (refill_line),
        .read_data       (read_data),
        .miss_stall      (miss_stall),
        .drq             (drq),
        .access_l2_clean (access_l2_clean),
        .access_l2_dirty (access_l2_dirty),
        .arr             (arr)
    );

    ////////////////////
    // array model
    ////////////////////

    // registered read, one cycle after re
    always @(posedge clk) begin
        if (arr.re != 2'b00) begin
            if (arr.index == cur_index) begin
                way0 <= cur_way0;
                way1 <= cur_way1;
            end else begin
                way0 <= '0;                            // unused set
                way1 <= '0;
            end
        end
    end

    ////////////////////
    // helpers
    ////////////////////

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};  // taps 32 22 2 1
    endfunction

    task automatic fill_random(output dcache_pkg::line_t v);
        for (int b = 0; b < dcache_pkg::line_w; b++) begin
            lfsr_state = lfsr_next(lfsr_state);
            v[b] = lfsr_state[0];
        end
    endtask

    function automatic dcache_pkg::word_t word_of(input dcache_pkg::line_t l,
                                                  input dcache_pkg::offset_t off);
        return l[32*off +: 32];
    endfunction

    task automatic check_value(input string what, input logic [127:0] exp,
                               input logic [127:0] act);
        if (exp !== act) begin
            $display("Fail %s %s: expected %0h actual %0h", cur_test, what, exp, act);
            $display("SOME TESTS FAILED");
            $fatal(1, "stopped at first mismatch");
        end
    endtask

    task automatic set_row(input int i, input string name, input dcache_pkg::index_t index,
                           input dcache_pkg::offset_t off, input logic write,
                           input dcache_pkg::word_t wr_data, input logic [1:0] valid,
                           input logic [1:0] dirty, input dcache_pkg::tag_t tag0,
                           input dcache_pkg::tag_t tag1, input logic lru_bit,
                           input int grant_delay, input logic busy_first);
        logic hit0;
        logic hit1;
        logic way;
        hit0 = valid[0] && (tag0 == tag_a);
        hit1 = valid[1] && (tag1 == tag_a);
        if (hit0 || hit1) begin
            way = hit0 ? 1'b0 : 1'b1;                  // way 0 first
        end else if (!valid[0]) begin
            way = 1'b0;
        end else begin
            way = valid[1] ? lru_bit : 1'b1;
        end
        rows[i] = '{name, {tag_a, index, off}, write, wr_data, valid, dirty, tag0, tag1,
                    lru_bit, grant_delay, busy_first, hit0 || hit1, way,
                    !(hit0 || hit1) && valid[way] && dirty[way]};
    endtask

    task automatic run_row(input int i);
        test_row_t           r;
        dcache_pkg::line_t   line0;
        dcache_pkg::line_t   line1;
        dcache_pkg::line_t   fill;
        dcache_pkg::offset_t off;
        logic [1:0]          exp_we;
        logic                last;
        r = rows[i];
        cur_test = r.name;
        off = r.addr[1:0];
        exp_we = 2'b01 << r.exp_way;
        fill_random(line0);
        fill_random(line1);
        fill_random(fill);
        @(posedge clk);
        cur_way0  <= {r.valid[0], r.dirty[0], r.tag0, line0};
        cur_way1  <= {r.valid[1], r.dirty[1], r.tag1, line1};
        cur_index <= r.addr[9:2];
        lru       <= r.lru;
        req       <= {r.write, r.addr, r.wr_data};
        access    <= 1'b1;
        l2_grant  <= (r.grant_delay == 0) || r.busy_first;   // busy must override grant
        l2_busy   <= r.busy_first && (r.grant_delay > 0);
        @(negedge clk);
        check_value("accept re", 2'b11, arr.re);
        @(posedge clk);                                // accept
        access <= 1'b0;
        @(negedge clk);
        if (r.exp_hit) begin
            check_value("miss_stall", 0, miss_stall);
            if (r.write) begin
                check_value("we", exp_we, arr.we);
                check_value("line_we", 0, arr.line_we);
                check_value("word_wd", r.wr_data, arr.word_wd);
                check_value("index", r.addr[9:2], arr.index);
                check_value("offset", off, arr.offset);
            end else begin
                check_value("we", 0, arr.we);
                check_value("read_data", word_of(r.exp_way ? line1 : line0, off), read_data);
            end
            @(posedge clk);
        end else begin
            for (int c = 0; c <= r.grant_delay; c++) begin
                last = (c == r.grant_delay);           // grant seen in this cycle
                check_value("miss_stall", 1, miss_stall);
                check_value("drq", 1, drq);
                check_value("access_l2_clean", last && !r.exp_dirty, access_l2_clean);
                check_value("access_l2_dirty", last && r.exp_dirty, access_l2_dirty);
                @(posedge clk);
                l2_busy  <= 1'b0;
                l2_grant <= (c + 1 == r.grant_delay);
                @(negedge clk);
            end
            check_value("pending miss_stall", 1, miss_stall);
            check_value("pending we", 0, arr.we);
            @(posedge clk);
            refill_valid <= 1'b1;
            refill_line  <= fill;
            @(negedge clk);
            check_value("refill we", exp_we, arr.we);
            check_value("refill line_we", 1, arr.line_we);
            check_value("line_wd", fill, arr.line_wd);
            check_value("tag_wd", {1'b1, tag_a}, arr.tag_wd);
            check_value("refill index", r.addr[9:2], arr.index);
            check_value("refill miss_stall", r.write, miss_stall);
            if (!r.write) begin
                check_value("refill read_data", word_of(fill, off), read_data);
            end
            @(posedge clk);
            refill_valid <= 1'b0;
            if (r.write) begin
                @(negedge clk);                        // merge cycle
                check_value("merge we", exp_we, arr.we);
                check_value("merge line_we", 0, arr.line_we);
                check_value("merge word_wd", r.wr_data, arr.word_wd);
                check_value("merge offset", off, arr.offset);
                check_value("merge miss_stall", 0, miss_stall);
                @(posedge clk);
            end
        end
    endtask

    ////////////////////
    // test sequence
    ////////////////////

    initial begin
        #(num_rows * 40 * 40);
        $display("run timed out before the last test row finished");
        $display("SOME TESTS FAILED");
        $fatal(1, "watchdog expired");
    end

    initial begin
        rst          = 1'b1;
        req          = '0;
        access       = 1'b0;
        lru          = 1'b0;
        l2_busy      = 1'b0;
        l2_grant     = 1'b0;
        refill_valid = 1'b0;
        refill_line  = '0;
        cur_way0     = '0;
        cur_way1     = '0;
        cur_index    = '0;
        cur_test     = "reset";
        set_row(0, "rd_hit_w0_o0", 8'h03, 2'd0, 1'b0, 32'h0, 2'b11, 2'b00, tag_a, tag_b,
                1'b0, 0, 1'b0);
        set_row(1, "rd_hit_w0_o1", 8'h04, 2'd1, 1'b0, 32'h0, 2'b01, 2'b00, tag_a, tag_b,
                1'b1, 0, 1'b0);
        set_row(2, "rd_hit_w1_o2", 8'h10, 2'd2, 1'b0, 32'h0, 2'b11, 2'b10, tag_b, tag_a,
                1'b0, 0, 1'b0);
        set_row(3, "rd_hit_both_o3", 8'h21, 2'd3, 1'b0, 32'h0, 2'b11, 2'b00, tag_a, tag_a,
                1'b1, 0, 1'b0);
        set_row(4, "wr_hit_w1", 8'h40, 2'd1, 1'b1, 32'hcafe_0001, 2'b11, 2'b00, tag_c, tag_a,
                1'b0, 0, 1'b0);
        set_row(5, "wr_hit_w0", 8'h41, 2'd3, 1'b1, 32'h1234_5678, 2'b11, 2'b01, tag_a, tag_c,
                1'b0, 0, 1'b0);
        set_row(6, "rd_miss_empty0", 8'h52, 2'd2, 1'b0, 32'h0, 2'b10, 2'b00, tag_a, tag_b,
                1'b0, 0, 1'b0);
        set_row(7, "rd_miss_lru1", 8'h60, 2'd1, 1'b0, 32'h0, 2'b11, 2'b01, tag_b, tag_c,
                1'b1, 0, 1'b0);
        set_row(8, "rd_miss_dirty_busy", 8'h7f, 2'd0, 1'b0, 32'h0, 2'b11, 2'b01, tag_b, tag_c,
                1'b0, 3, 1'b1);
        set_row(9, "wr_miss_clean_wait", 8'h80, 2'd3, 1'b1, 32'hdead_beef, 2'b01, 2'b00,
                tag_b, tag_c, 1'b0, 2, 1'b0);
        set_row(10, "wr_miss_dirty_busy", 8'h9a, 2'd2, 1'b1, 32'h0bad_f00d, 2'b11, 2'b10,
                tag_c, tag_b, 1'b1, 1, 1'b1);
        set_row(11, "rd_miss_stale_dirty", 8'hc3, 2'd1, 1'b0, 32'h0, 2'b10, 2'b01, tag_c, tag_b,
                1'b1, 0, 1'b0);
        repeat (10) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        check_value("miss_stall", 0, miss_stall);
        check_value("drq", 0, drq);
        check_value("access_l2_clean", 0, access_l2_clean);
        check_value("access_l2_dirty", 0, access_l2_dirty);
        check_value("re", 0, arr.re);
        check_value("we", 0, arr.we);
        for (int i = 0; i < num_rows; i++) begin
            run_row(i);
        end
        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

// File: dcache_ctrl.f
rtl/dcache_pkg.sv
rtl/dcache_way_select.sv
rtl/dcache_read_path.sv
rtl/dcache_ctrl_fsm.sv
rtl/dcache_ctrl.sv
sim/dcache_ctrl_checker.sv
sim/dcache_ctrl_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the cache controller testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module dcache_ctrl_tb -f dcache_ctrl.f -o dcache_sim \
    || { echo "build failed"; exit 1; }

./obj_dir/dcache_sim > sim.log 2>&1
cat sim.log

grep -q "^ALL TESTS PASSED$" sim.log && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
